// ==== lane_defs.svh ====
/*
 * Sizes and latency of the vector-lane multiply unit.
 * OPQUEUE_DEPTH must be a power of two, since the queue pointers wrap
 * by overflow. MUL_LAT must be at least 2, because products and the
 * accumulate step occupy separate stages.
 */
`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

// Datapath
`define LANE_WORD_W 64
`define LANE_BYTES 8

// Buffering
`define OPQUEUE_DEPTH 4
`define OBUF_DEPTH 4

// Multiplier pipeline stages
`define MUL_LAT 3

// Instruction bookkeeping
`define NR_VINSN 8
`define VLEN_W 16
`define VADDR_W 12

`endif

// ==== lane_pkg.sv ====
/*
 * Datapath types of the multiply lane.
 * The element-width encoding is log2 of the element size in bytes, and
 * the SIMD adder relies on it.
 */
`default_nettype none

`include "lane_defs.svh"

package lane_pkg;

  // One data word and its byte mask
  typedef logic [`LANE_WORD_W-1:0] word_t;
  typedef logic [`LANE_BYTES-1:0]  bmask_t;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULH  = 2'd1,
    VMACC  = 2'd2,
    VNMSAC = 2'd3
  } lane_op_e;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } elem_width_e;

  // Operand word as delivered by the register file
  typedef struct packed {
    word_t word;
    logic  valid;
  } operand_t;

endpackage

`default_nettype wire

// ==== mul_lane.sv ====
/*
 * Vector-lane integer multiply unit, top level.
 * Back-pressure from wgnt_i propagates through the result buffer and
 * the multiplier up to operand_ready_o without losing data.
 */
`default_nettype none

`include "lane_defs.svh"

module mul_lane (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  vinsn_pkg::operation_t    operation_i,
  input  logic                     op_valid_i,
  output logic                     op_ready_o,
  input  lane_pkg::operand_t [3:0] operand_i,
  output logic                     operand_ready_o,
  output vinsn_pkg::wreq_t         wreq_o,
  input  logic                     wgnt_i,
  output vinsn_pkg::done_vec_t     done_o
);
  import lane_pkg::*;
  import vinsn_pkg::*;

  // Issue side
  logic        mul_valid;
  logic        mul_ready;
  lane_op_e    mul_op;
  elem_width_e mul_ew;
  word_t       mul_a;
  word_t       mul_b;
  word_t       mul_c;
  bmask_t      mul_mask;

  // Result path
  logic        res_valid;
  logic        res_ready;
  word_t       res_word;
  word_t       obuf_rdata;
  logic        obuf_rvalid;
  logic        obuf_rpop;

  // Commit side
  operation_t  commit_insn;
  logic        commit_valid;
  logic        commit_pop;

  mul_opqueue u_mul_opqueue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .operation_i     (operation_i),
    .op_valid_i      (op_valid_i),
    .op_ready_o      (op_ready_o),
    .operand_i       (operand_i),
    .operand_ready_o (operand_ready_o),
    .mul_valid_o     (mul_valid),
    .mul_ready_i     (mul_ready),
    .mul_op_o        (mul_op),
    .mul_ew_o        (mul_ew),
    .mul_a_o         (mul_a),
    .mul_b_o         (mul_b),
    .mul_c_o         (mul_c),
    .mul_mask_o      (mul_mask),
    .commit_insn_o   (commit_insn),
    .commit_valid_o  (commit_valid),
    .commit_pop_i    (commit_pop)
  );

  simd_mul_pipe u_simd_mul_pipe (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (mul_valid),
    .ready_o  (mul_ready),
    .op_i     (mul_op),
    .ew_i     (mul_ew),
    .a_i      (mul_a),
    .b_i      (mul_b),
    .c_i      (mul_c),
    .mask_i   (mul_mask),
    .valid_o  (res_valid),
    .ready_i  (res_ready),
    .result_o (res_word)
  );

  result_obuf u_result_obuf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wdata_i  (res_word),
    .wvalid_i (res_valid),
    .wready_o (res_ready),
    .rdata_o  (obuf_rdata),
    .rvalid_o (obuf_rvalid),
    .rpop_i   (obuf_rpop)
  );

  vrf_writer u_vrf_writer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rdata_i        (obuf_rdata),
    .rvalid_i       (obuf_rvalid),
    .rpop_o         (obuf_rpop),
    .commit_insn_i  (commit_insn),
    .commit_valid_i (commit_valid),
    .commit_pop_o   (commit_pop),
    .wreq_o         (wreq_o),
    .wgnt_i         (wgnt_i),
    .done_o         (done_o)
  );

endmodule

`default_nettype wire

// ==== mul_opqueue.sv ====
/*
 * Instruction queue of the multiply lane.
 * Issue and commit heads advance independently. An entry is freed only
 * when the writer reports its last word, so op_ready_o is low while
 * OPQUEUE_DEPTH instructions are uncommitted.
 */
`default_nettype none

`include "lane_defs.svh"

module mul_opqueue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction port
  input  vinsn_pkg::operation_t    operation_i,
  input  logic                     op_valid_i,
  output logic                     op_ready_o,
  // Operands in the order mask, a, b, c
  input  lane_pkg::operand_t [3:0] operand_i,
  output logic                     operand_ready_o,
  // Multiplier input
  output logic                     mul_valid_o,
  input  logic                     mul_ready_i,
  output lane_pkg::lane_op_e       mul_op_o,
  output lane_pkg::elem_width_e    mul_ew_o,
  output lane_pkg::word_t          mul_a_o,
  output lane_pkg::word_t          mul_b_o,
  output lane_pkg::word_t          mul_c_o,
  output lane_pkg::bmask_t         mul_mask_o,
  // Commit head towards the writer
  output vinsn_pkg::operation_t    commit_insn_o,
  output logic                     commit_valid_o,
  input  logic                     commit_pop_i
);
  import lane_pkg::*;
  import vinsn_pkg::*;

  typedef logic [$clog2(`OPQUEUE_DEPTH)-1:0] qptr_t;
  typedef logic [$clog2(`OPQUEUE_DEPTH):0]   qcnt_t;

  operation_t insn_q [`OPQUEUE_DEPTH];

  qptr_t accept_ptr_q;
  qptr_t issue_ptr_q;
  qptr_t commit_ptr_q;
  qcnt_t issue_cnt_q;
  qcnt_t commit_cnt_q;
  vlen_t issue_left_q;

  operation_t issue_insn;
  qptr_t      issue_ptr_nxt;
  logic       op_accept;
  logic       issue_valid;
  logic       need_c;
  logic       operand_ok;
  logic       issue_fire;
  logic       issue_done;

  assign op_ready_o    = commit_cnt_q != qcnt_t'(`OPQUEUE_DEPTH);
  assign op_accept     = op_valid_i && op_ready_o;
  assign issue_valid   = issue_cnt_q != '0;
  assign issue_insn    = insn_q[issue_ptr_q];
  assign issue_ptr_nxt = issue_ptr_q + 1'b1;

  // ------------------------------------------------------------
  // Operand check and issue
  // ------------------------------------------------------------
  assign need_c     = issue_insn.op inside {VMACC, VNMSAC};
  assign operand_ok = operand_i[1].valid && operand_i[2].valid
                   && (operand_i[3].valid || !need_c)
                   && (operand_i[0].valid || !issue_insn.masked);

  assign mul_valid_o     = issue_valid && operand_ok;
  assign issue_fire      = mul_valid_o && mul_ready_i;
  assign operand_ready_o = issue_fire;
  // Last word of the head once the byte counter drops to zero or below
  assign issue_done      = issue_fire && (issue_left_q <= vlen_t'(`LANE_BYTES));

  assign mul_op_o = issue_insn.op;
  assign mul_ew_o = issue_insn.ew;
  assign mul_a_o  = operand_i[1].word;
  assign mul_b_o  = operand_i[2].word;
  assign mul_c_o  = operand_i[3].word;

  // One mask bit per byte, taken from bit 8k of the mask word
  always_comb begin
    for (int k = 0; k < `LANE_BYTES; k++) begin
      mul_mask_o[k] = issue_insn.masked ? operand_i[0].word[8*k] : 1'b1;
    end
  end

  assign commit_insn_o  = insn_q[commit_ptr_q];
  assign commit_valid_o = commit_cnt_q != '0;

  // ------------------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (op_accept) begin
      insn_q[accept_ptr_q] <= operation_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issue_left_q <= '0;
    end else begin
      if (op_accept) begin
        accept_ptr_q <= accept_ptr_q + 1'b1;
      end
      if (issue_done) begin
        issue_ptr_q <= issue_ptr_nxt;
      end
      if (commit_pop_i) begin
        commit_ptr_q <= commit_ptr_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + qcnt_t'(op_accept) - qcnt_t'(issue_done);
      commit_cnt_q <= commit_cnt_q + qcnt_t'(op_accept) - qcnt_t'(commit_pop_i);

      // Byte counter follows whichever instruction is at the issue head
      if (issue_done) begin
        if (issue_cnt_q > qcnt_t'(1)) begin
          issue_left_q <= insn_q[issue_ptr_nxt].len;
        end else if (op_accept) begin
          issue_left_q <= operation_i.len;
        end
      end else if (issue_fire) begin
        issue_left_q <= issue_left_q - vlen_t'(`LANE_BYTES);
      end else if (op_accept && issue_cnt_q == '0) begin
        issue_left_q <= operation_i.len;
      end
    end
  end

endmodule

`default_nettype wire

// ==== result_obuf.sv ====
/*
 * Result FIFO between multiplier and write-back.
 * No fall-through, a word is readable the cycle after it is written.
 * Write while full and pop while empty are ignored.
 */
`default_nettype none

`include "lane_defs.svh"

module result_obuf (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  lane_pkg::word_t wdata_i,
  input  logic            wvalid_i,
  output logic            wready_o,
  output lane_pkg::word_t rdata_o,
  output logic            rvalid_o,
  input  logic            rpop_i
);
  import lane_pkg::*;

  typedef logic [$clog2(`OBUF_DEPTH)-1:0] bptr_t;
  typedef logic [$clog2(`OBUF_DEPTH):0]   bcnt_t;

  word_t mem_q [`OBUF_DEPTH];
  bptr_t wr_ptr_q;
  bptr_t rd_ptr_q;
  bcnt_t cnt_q;
  logic  push;
  logic  pop;

  assign wready_o = cnt_q != bcnt_t'(`OBUF_DEPTH);
  assign rvalid_o = cnt_q != '0;
  assign rdata_o  = mem_q[rd_ptr_q];

  assign push = wvalid_i && wready_o;
  assign pop  = rpop_i && rvalid_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == bptr_t'(`OBUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == bptr_t'(`OBUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + bcnt_t'(push) - bcnt_t'(pop);
    end
  end

endmodule

`default_nettype wire

// ==== simd_mul_pipe.sv ====
/*
 * Pipelined SIMD integer multiply-accumulate, MUL_LAT stages.
 * Stage 0 holds the element products, stage 1 the accumulated result,
 * later stages only carry it. Results wrap to the element width and
 * masked bytes read as zero.
 */
`default_nettype none

`include "lane_defs.svh"

module simd_mul_pipe (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  lane_pkg::lane_op_e    op_i,
  input  lane_pkg::elem_width_e ew_i,
  input  lane_pkg::word_t       a_i,
  input  lane_pkg::word_t       b_i,
  input  lane_pkg::word_t       c_i,
  input  lane_pkg::bmask_t      mask_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output lane_pkg::word_t       result_o
);
  import lane_pkg::*;

  typedef struct packed {
    lane_op_e    op;
    elem_width_e ew;
    word_t       hi;
    word_t       lo;
    word_t       c;
    bmask_t      mask;
  } prod_t;

  typedef struct packed {
    word_t  res;
    bmask_t mask;
  } res_t;

  // Signed element products, high halves and low halves kept in place
  function automatic logic [2*`LANE_WORD_W-1:0] elem_mul(word_t a, word_t b,
                                                         elem_width_e ew);
    word_t               lo;
    word_t               hi;
    logic signed [15:0]  p8;
    logic signed [31:0]  p16;
    logic signed [63:0]  p32;
    logic signed [127:0] p64;
    lo = '0;
    hi = '0;
    case (ew)
      EW8: begin
        for (int i = 0; i < 8; i++) begin
          p8 = $signed(a[8*i +: 8]) * $signed(b[8*i +: 8]);
          {hi[8*i +: 8], lo[8*i +: 8]} = p8;
        end
      end
      EW16: begin
        for (int i = 0; i < 4; i++) begin
          p16 = $signed(a[16*i +: 16]) * $signed(b[16*i +: 16]);
          {hi[16*i +: 16], lo[16*i +: 16]} = p16;
        end
      end
      EW32: begin
        for (int i = 0; i < 2; i++) begin
          p32 = $signed(a[32*i +: 32]) * $signed(b[32*i +: 32]);
          {hi[32*i +: 32], lo[32*i +: 32]} = p32;
        end
      end
      default: begin
        p64 = $signed(a) * $signed(b);
        {hi, lo} = p64;
      end
    endcase
    return {hi, lo};
  endfunction

  // Byte-sliced adder, carries cut at element boundaries
  function automatic word_t elem_acc(word_t c, word_t p, elem_width_e ew, logic sub);
    word_t      r;
    logic [8:0] sum;
    logic       carry;
    carry = 1'b0;
    for (int k = 0; k < `LANE_BYTES; k++) begin
      if ((k & ((1 << ew) - 1)) == 0) begin
        carry = sub;
      end
      sum = {1'b0, c[8*k +: 8]} + {1'b0, p[8*k +: 8] ^ {8{sub}}} + {8'b0, carry};
      r[8*k +: 8] = sum[7:0];
      carry = sum[8];
    end
    return r;
  endfunction

  prod_t                  prod_q;
  res_t [`MUL_LAT-1:1]    res_q;
  logic [`MUL_LAT-1:0]    valid_q;
  logic [`MUL_LAT:0]      adv;
  word_t                  res_d;
  res_t                   out_s;

  // A stage may load when it is empty or its successor moves on
  always_comb begin
    adv[`MUL_LAT] = ready_i;
    for (int k = `MUL_LAT - 1; k >= 0; k--) begin
      adv[k] = !valid_q[k] || adv[k+1];
    end
  end

  assign ready_o = adv[0];
  assign valid_o = valid_q[`MUL_LAT-1];

  always_comb begin
    res_d = prod_q.lo;
    case (prod_q.op)
      VMULH:   res_d = prod_q.hi;
      VMACC:   res_d = elem_acc(prod_q.c, prod_q.lo, prod_q.ew, 1'b0);
      VNMSAC:  res_d = elem_acc(prod_q.c, prod_q.lo, prod_q.ew, 1'b1);
      default: res_d = prod_q.lo;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (adv[0]) begin
        valid_q[0] <= valid_i;
      end
      for (int k = 1; k < `MUL_LAT; k++) begin
        if (adv[k]) begin
          valid_q[k] <= valid_q[k-1];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (adv[0] && valid_i) begin
      {prod_q.hi, prod_q.lo} <= elem_mul(a_i, b_i, ew_i);
      prod_q.op              <= op_i;
      prod_q.ew              <= ew_i;
      prod_q.c               <= c_i;
      prod_q.mask            <= mask_i;
    end
    if (adv[1] && valid_q[0]) begin
      res_q[1].res  <= res_d;
      res_q[1].mask <= prod_q.mask;
    end
    for (int k = 2; k < `MUL_LAT; k++) begin
      if (adv[k] && valid_q[k-1]) begin
        res_q[k] <= res_q[k-1];
      end
    end
  end

  // Mask tag zeroes inactive bytes
  assign out_s = res_q[`MUL_LAT-1];

  always_comb begin
    for (int k = 0; k < `LANE_BYTES; k++) begin
      result_o[8*k +: 8] = out_s.res[8*k +: 8] & {8{out_s.mask[k]}};
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
lane_pkg.sv
vinsn_pkg.sv
mul_opqueue.sv
simd_mul_pipe.sv
result_obuf.sv
vrf_writer.sv
mul_lane.sv
tb_mul_lane.sv

// ==== tb_lane_model.svh ====
/*
 * Reference model and random source for the multiply-lane testbench.
 * Included inside the testbench module after the package imports.
 * The generator state is shared, so stimulus is drawn by one process
 * at a time.
 */
`ifndef TB_LANE_MODEL_SVH
`define TB_LANE_MODEL_SVH

logic [31:0] lcg_state = 32'hb4d45f02;

// Linear congruential generator step
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Low LCG bits repeat quickly, so draw from the upper ones
function automatic int rand_below(int n);
  logic [31:0] r;
  r = next_rand();
  return int'(r[31:8] % n);
endfunction

// Random word with an occasional corner pattern
function automatic word_t rand_word();
  word_t       w;
  logic [31:0] r;
  case (rand_below(8))
    0: w = '1;
    1: w = {8{8'h80}};
    default: begin
      for (int k = 0; k < 4; k++) begin
        r = next_rand();
        w[16*k +: 16] = r[31:16];
      end
    end
  endcase
  return w;
endfunction

// Byte k is active when unmasked or when bit 8k of the mask word is set
function automatic bmask_t model_bmask(logic masked, word_t mword);
  bmask_t m;
  for (int k = 0; k < `LANE_BYTES; k++) begin
    m[k] = masked ? mword[8*k] : 1'b1;
  end
  return m;
endfunction

// One result word, element by element, wrapped to the element width
function automatic word_t model_word(lane_op_e op, elem_width_e ew, word_t a, word_t b,
                                     word_t c, bmask_t m);
  int                  w;
  logic [127:0]        ua;
  logic [127:0]        ub;
  logic [127:0]        uc;
  logic signed [127:0] sa;
  logic signed [127:0] sb;
  logic signed [127:0] prod;
  logic [127:0]        full;
  word_t               res;
  w   = 8 << int'(ew);
  res = '0;
  for (int e = 0; e < 64 / w; e++) begin
    ua = '0;
    ub = '0;
    uc = '0;
    for (int i = 0; i < w; i++) begin
      ua[i] = a[e*w+i];
      ub[i] = b[e*w+i];
      uc[i] = c[e*w+i];
    end
    // Sign-extend both factors to 128 bits
    sa   = $signed(ua << (128 - w)) >>> (128 - w);
    sb   = $signed(ub << (128 - w)) >>> (128 - w);
    prod = sa * sb;
    case (op)
      VMUL:    full = prod;
      VMULH:   full = prod >>> w;
      VMACC:   full = uc + prod;
      default: full = uc - prod;
    endcase
    for (int i = 0; i < w; i++) begin
      res[e*w+i] = full[i];
    end
  end
  for (int k = 0; k < `LANE_BYTES; k++) begin
    if (!m[k]) begin
      res[8*k +: 8] = 8'h00;
    end
  end
  return res;
endfunction

`endif

// ==== tb_mul_lane.sv ====
/*
 * Testbench of the vector-lane multiply unit.
 * Random instructions, operand timing and grant stalls from a fixed
 * seed. Every write request is compared with a precomputed word list,
 * and the run stops at the first mismatch.
 */
`default_nettype none

`include "lane_defs.svh"

module tb_mul_lane;
  timeunit 1ns;
  timeprecision 100ps;

  import lane_pkg::*;
  import vinsn_pkg::*;

  localparam int NUM_INSN  = 40;
  localparam int MAX_WORDS = NUM_INSN * 8;
  localparam int TIMEOUT   = 50000;

  logic             clk_i;
  logic             rst_ni;
  operation_t       operation_i;
  logic             op_valid_i;
  logic             op_ready_o;
  operand_t [3:0]   operand_i;
  logic             operand_ready_o;
  wreq_t            wreq_o;
  logic             wgnt_i;
  done_vec_t        done_o;

  // Stimulus and expected results, in issue order
  operation_t insn_list [NUM_INSN];
  word_t      opnd_m [MAX_WORDS];
  word_t      opnd_a [MAX_WORDS];
  word_t      opnd_b [MAX_WORDS];
  word_t      opnd_c [MAX_WORDS];
  word_t      exp_word [MAX_WORDS];
  vaddr_t     exp_addr [MAX_WORDS];
  vid_t       exp_id [MAX_WORDS];
  logic       exp_last [MAX_WORDS];
  int         total_words;

  // Driver state
  logic       run_en;
  int         insn_idx;
  int         word_idx;
  logic [3:0] opnd_vld;
  int         stall_left;

  // Monitor state
  int         inflight;
  int         granted_cnt;
  logic       full_seen;

  `include "tb_lane_model.svh"

  mul_lane u_mul_lane (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .operation_i     (operation_i),
    .op_valid_i      (op_valid_i),
    .op_ready_o      (op_ready_o),
    .operand_i       (operand_i),
    .operand_ready_o (operand_ready_o),
    .wreq_o          (wreq_o),
    .wgnt_i          (wgnt_i),
    .done_o          (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Error reporting and compare tasks
  // ------------------------------------------------------------
  task automatic report_error(string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare_word(word_t got, word_t exp, string what);
    if (got !== exp) begin
      report_error($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_req(vaddr_t got_addr, vid_t got_id, vaddr_t exp_addr_v,
                             vid_t exp_id_v, string what);
    if (got_addr !== exp_addr_v || got_id !== exp_id_v) begin
      report_error($sformatf("FAILED at %0t: %s got addr %h id %0d expected addr %h id %0d",
                             $time, what, got_addr, got_id, exp_addr_v, exp_id_v));
    end
  endtask

  task automatic compare_done(done_vec_t got, done_vec_t exp, string what);
    if (got !== exp) begin
      report_error($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic compare_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      report_error($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // Every op and width pair appears, lengths 1 to 64 bytes
  task automatic build_stimulus();
    operation_t insn;
    int         nwords;
    total_words = 0;
    for (int i = 0; i < NUM_INSN; i++) begin
      insn.op     = lane_op_e'(i % 4);
      insn.ew     = elem_width_e'((i / 4) % 4);
      insn.masked = rand_below(2) == 1;
      insn.id     = vid_t'(i % `NR_VINSN);
      insn.addr   = vaddr_t'(rand_below(1 << `VADDR_W));
      insn.len    = vlen_t'(1 + rand_below(64));
      insn_list[i] = insn;
      nwords = (int'(insn.len) + 7) / 8;
      for (int j = 0; j < nwords; j++) begin
        opnd_m[total_words]   = rand_word();
        opnd_a[total_words]   = rand_word();
        opnd_b[total_words]   = rand_word();
        opnd_c[total_words]   = rand_word();
        exp_word[total_words] = model_word(insn.op, insn.ew, opnd_a[total_words],
                                           opnd_b[total_words], opnd_c[total_words],
                                           model_bmask(insn.masked, opnd_m[total_words]));
        exp_addr[total_words] = vaddr_t'(insn.addr + j);
        exp_id[total_words]   = insn.id;
        exp_last[total_words] = j == nwords - 1;
        total_words++;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Drivers for instructions, operands and grants
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    if (run_en) begin
      if (op_valid_i && op_ready_o) begin
        insn_idx = insn_idx + 1;
      end
      if (insn_idx >= NUM_INSN) begin
        op_valid_i <= 1'b0;
      end else if (!(op_valid_i && !op_ready_o)) begin
        // Valid holds until the transfer, otherwise random gaps
        if (rand_below(4) != 0) begin
          operation_i <= insn_list[insn_idx];
          op_valid_i  <= 1'b1;
        end else begin
          op_valid_i  <= 1'b0;
        end
      end

      if (operand_ready_o) begin
        word_idx = word_idx + 1;
        opnd_vld = '0;
      end
      if (word_idx < total_words) begin
        // Valid bits come up one by one at random
        for (int k = 0; k < 4; k++) begin
          if (!opnd_vld[k] && rand_below(3) != 0) begin
            opnd_vld[k] = 1'b1;
          end
        end
        // Word is inverted until its valid bit comes up
        operand_i[0].word <= opnd_vld[0] ? opnd_m[word_idx] : ~opnd_m[word_idx];
        operand_i[1].word <= opnd_vld[1] ? opnd_a[word_idx] : ~opnd_a[word_idx];
        operand_i[2].word <= opnd_vld[2] ? opnd_b[word_idx] : ~opnd_b[word_idx];
        operand_i[3].word <= opnd_vld[3] ? opnd_c[word_idx] : ~opnd_c[word_idx];
      end else begin
        opnd_vld = '0;
      end
      for (int k = 0; k < 4; k++) begin
        operand_i[k].valid <= opnd_vld[k];
      end

      // Grant with long low stretches now and then
      if (stall_left > 0) begin
        stall_left = stall_left - 1;
        wgnt_i <= 1'b0;
      end else if (rand_below(16) == 0) begin
        stall_left = 8 + rand_below(20);
        wgnt_i <= 1'b0;
      end else begin
        wgnt_i <= rand_below(4) != 0;
      end
    end
  end

  // ------------------------------------------------------------
  // Monitor
  // ------------------------------------------------------------
  // Req fields are compared every cycle, so they must hold until the grant
  always @(posedge clk_i) begin
    done_vec_t exp_done;
    logic      grant;
    logic      last_grant;
    if (run_en) begin
      compare_flag(op_ready_o, inflight < `OPQUEUE_DEPTH, "op_ready_o");
      if (!op_ready_o) begin
        full_seen <= 1'b1;
      end
      grant      = wreq_o.req && wgnt_i;
      last_grant = 1'b0;
      exp_done   = '0;
      if (wreq_o.req) begin
        if (granted_cnt >= total_words) begin
          report_error("Write request seen after all expected words were written");
        end
        compare_word(wreq_o.wdata, exp_word[granted_cnt],
                     $sformatf("wdata of word %0d", granted_cnt));
        compare_req(wreq_o.addr, wreq_o.id, exp_addr[granted_cnt], exp_id[granted_cnt],
                    $sformatf("request of word %0d", granted_cnt));
        last_grant = grant && exp_last[granted_cnt];
        if (last_grant) begin
          exp_done[exp_id[granted_cnt]] = 1'b1;
        end
      end
      compare_done(done_o, exp_done, "done_o");
      inflight <= inflight + int'(op_valid_i && op_ready_o) - int'(last_grant);
      if (grant) begin
        granted_cnt <= granted_cnt + 1;
      end
    end
  end

  initial begin
    int cycles;
    rst_ni      = 1'b0;
    operation_i = '0;
    op_valid_i  = 1'b0;
    operand_i   = '0;
    wgnt_i      = 1'b0;
    run_en      = 1'b0;
    insn_idx    = 0;
    word_idx    = 0;
    opnd_vld    = '0;
    stall_left  = 0;
    inflight    = 0;
    granted_cnt = 0;
    full_seen   = 1'b0;
    build_stimulus();

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    compare_flag(op_ready_o, 1'b1, "op_ready_o after reset");
    compare_flag(operand_ready_o, 1'b0, "operand_ready_o after reset");
    compare_flag(wreq_o.req, 1'b0, "req after reset");
    compare_done(done_o, '0, "done_o after reset");
    run_en <= 1'b1;

    cycles = 0;
    while (granted_cnt < total_words) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("Timeout while waiting for all result words to be written back");
      end
    end
    // A few idle cycles to catch extra requests or pulses
    repeat (16) @(posedge clk_i);
    if (!full_seen) begin
      report_error("The instruction queue never became full during the run");
    end
    if (inflight != 0) begin
      report_error("Instructions were left uncommitted at the end of the run");
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vinsn_pkg.sv ====
/*
 * Instruction-level types of the multiply lane.
 * The length counts bytes, the address counts 64-bit words.
 */
`default_nettype none

`include "lane_defs.svh"

package vinsn_pkg;

  typedef logic [`VLEN_W-1:0]            vlen_t;
  typedef logic [`VADDR_W-1:0]           vaddr_t;
  typedef logic [$clog2(`NR_VINSN)-1:0]  vid_t;
  typedef logic [`NR_VINSN-1:0]          done_vec_t;

  // One vector instruction as accepted by the lane
  typedef struct packed {
    lane_pkg::lane_op_e    op;
    lane_pkg::elem_width_e ew;
    logic                  masked;
    vid_t                  id;
    vaddr_t                addr;
    vlen_t                 len;
  } operation_t;

  // Write-back request, req acts as valid
  typedef struct packed {
    logic            req;
    vaddr_t          addr;
    vid_t            id;
    lane_pkg::word_t wdata;
  } wreq_t;

endpackage

`default_nettype wire

// ==== vrf_writer.sv ====
/*
 * Write-back sequencer on the commit side.
 * Words of the buffer belong to the commit-head instruction in order.
 * Address and byte counter come straight from the head until its first
 * grant, then from local registers.
 */
`default_nettype none

`include "lane_defs.svh"

module vrf_writer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Result buffer head
  input  lane_pkg::word_t       rdata_i,
  input  logic                  rvalid_i,
  output logic                  rpop_o,
  // Commit-head instruction
  input  vinsn_pkg::operation_t commit_insn_i,
  input  logic                  commit_valid_i,
  output logic                  commit_pop_o,
  // Write port and completion
  output vinsn_pkg::wreq_t      wreq_o,
  input  logic                  wgnt_i,
  output vinsn_pkg::done_vec_t  done_o
);
  import vinsn_pkg::*;

  logic   loaded_q;
  vaddr_t addr_q;
  vlen_t  left_q;

  vaddr_t cur_addr;
  vlen_t  cur_left;
  logic   grant;
  logic   last;

  assign cur_addr = loaded_q ? addr_q : commit_insn_i.addr;
  assign cur_left = loaded_q ? left_q : commit_insn_i.len;

  // Request fields stay put until the grant
  assign wreq_o.req   = rvalid_i && commit_valid_i;
  assign wreq_o.addr  = cur_addr;
  assign wreq_o.id    = commit_insn_i.id;
  assign wreq_o.wdata = rdata_i;

  assign grant        = wreq_o.req && wgnt_i;
  assign last         = cur_left <= vlen_t'(`LANE_BYTES);
  assign rpop_o       = grant;
  assign commit_pop_o = grant && last;

  always_comb begin
    done_o = '0;
    if (commit_pop_o) begin
      done_o[commit_insn_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q <= 1'b0;
      addr_q   <= '0;
      left_q   <= '0;
    end else if (grant) begin
      // Next head starts fresh after the last word
      loaded_q <= !last;
      addr_q   <= cur_addr + 1'b1;
      left_q   <= cur_left - vlen_t'(`LANE_BYTES);
    end
  end

endmodule

`default_nettype wire
